// ==== design/rhRegPkg.sv ====
//////////////////////////////////////////////////////////////////////
// Register offsets and CS1/CS2 field positions
// Host bus request and response structs
// Internal register write bundle
//////////////////////////////////////////////////////////////////////
`default_nettype none

package rhRegPkg;

   // Register select on the host bus
   typedef logic [1:0] rhRegOffset_t;

   localparam rhRegOffset_t cs1Offset = 2'd0;
   localparam rhRegOffset_t wcOffset  = 2'd1;
   localparam rhRegOffset_t baOffset  = 2'd2;
   localparam rhRegOffset_t cs2Offset = 2'd3;

   ///////////////////////////////////////////////////////////////////
   // CS1 fields
   localparam int cs1GoBit   = 0;
   localparam int cs1FuncLsb = 1;
   localparam int cs1FuncMsb = 5;
   // Read only
   localparam int cs1RdyBit  = 7;
   localparam int cs1BaeLsb  = 8;
   localparam int cs1BaeMsb  = 9;

   // CS2 fields, CLR is a write-one pulse
   localparam int cs2BaiBit  = 3;
   localparam int cs2ClrBit  = 5;

   ///////////////////////////////////////////////////////////////////
   typedef struct packed {
      logic         write;
      rhRegOffset_t offset;
      logic         loByte;
      logic         hiByte;
      logic [15:0]  data;
   } rhHostReq_t;

   typedef struct packed {
      logic [15:0] data;
   } rhHostRsp_t;

   // One-hot strobes, valid only in the accept cycle
   typedef struct packed {
      logic        cs1;
      logic        wc;
      logic        ba;
      logic        cs2;
      logic        loByte;
      logic        hiByte;
      logic [15:0] data;
   } rhRegWrite_t;

endpackage

`default_nettype wire

// ==== design/rhDmaPkg.sv ====
//////////////////////////////////////////////////////////////////////
// DMA side definitions
// Function code type and word transfer request
//////////////////////////////////////////////////////////////////////
`default_nettype none

package rhDmaPkg;

   // Unibus style 18-bit address
   localparam int rhAddrWidth = 18;

   typedef logic [4:0] rhFunc_t;

   // One word transfer, address is always even
   typedef struct packed {
      logic [rhAddrWidth-1:0] addr;
      rhFunc_t                func;
   } rhDmaReq_t;

endpackage

`default_nettype wire

// ==== design/rhRegDecode.sv ====
//////////////////////////////////////////////////////////////////////
// Host bus front end
// Request accept, write strobes by offset, read-back response
//////////////////////////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/100ps

module rhRegDecode (
   input  wire                      clk,
   input  wire                      rstN,
   input  wire rhRegPkg::rhHostReq_t hostReq,
   input  wire                      hostReqValid,
   output logic                     hostReqReady,
   output rhRegPkg::rhHostRsp_t     hostRsp,
   output logic                     hostRspValid,
   input  wire                      hostRspReady,
   output rhRegPkg::rhRegWrite_t    regWrite,
   input  wire  [15:0]              cs1Value,
   input  wire  [15:0]              wcValue,
   input  wire  [15:0]              baValue,
   input  wire  [15:0]              cs2Value
);

   import rhRegPkg::*;

   logic         accept;
   // High in the cycle after accept, registers have settled
   logic         captureStage;
   rhRegOffset_t pendingOffset;
   logic [15:0]  readMux;

   // Only one request in flight
   assign hostReqReady = !captureStage && !hostRspValid;
   assign accept       = hostReqValid && hostReqReady;

   ///////////////////////////////////////////////////////////////////
   // Write strobes
   always_comb
   begin
      regWrite        = '0;
      regWrite.loByte = hostReq.loByte;
      regWrite.hiByte = hostReq.hiByte;
      regWrite.data   = hostReq.data;
      if (accept && hostReq.write)
      begin
         case (hostReq.offset)
            cs1Offset: regWrite.cs1 = 1'b1;
            wcOffset:  regWrite.wc  = 1'b1;
            baOffset:  regWrite.ba  = 1'b1;
            default:   regWrite.cs2 = 1'b1;
         endcase
      end
   end

   // Read-back select
   always_comb
   begin
      case (pendingOffset)
         cs1Offset: readMux = cs1Value;
         wcOffset:  readMux = wcValue;
         baOffset:  readMux = baValue;
         default:   readMux = cs2Value;
      endcase
   end

   ///////////////////////////////////////////////////////////////////
   // Response handshake
   always_ff @(posedge clk)
   begin
      if (!rstN)
      begin
         captureStage <= 1'b0;
         hostRspValid <= 1'b0;
      end
      else
      begin
         captureStage <= accept;
         if (captureStage)
            hostRspValid <= 1'b1;
         else if (hostRspReady)
            hostRspValid <= 1'b0;
      end
   end

   // Offset and read data
   always_ff @(posedge clk)
   begin
      if (accept)
         pendingOffset <= hostReq.offset;
      if (captureStage)
         hostRsp.data <= readMux;
   end

   // Pending response must hold under back-pressure
   assert property (@(posedge clk) disable iff (!rstN)
      hostRspValid && !hostRspReady |=> hostRspValid && $stable(hostRsp));

endmodule

`default_nettype wire

// ==== design/rhControlStatus.sv ====
//////////////////////////////////////////////////////////////////////
// CS1 and CS2 registers
// GO start, ready flag, increment inhibit, controller clear
//////////////////////////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/100ps

module rhControlStatus (
   input  wire                       clk,
   input  wire                       rstN,
   input  wire rhRegPkg::rhRegWrite_t regWrite,
   input  wire                       seqDone,
   input  wire  [1:0]                baExt,
   output logic [15:0]               cs1Value,
   output logic [15:0]               cs2Value,
   output rhDmaPkg::rhFunc_t         func,
   output logic                      goStart,
   output logic                      ready,
   output logic                      incInhibit,
   output logic                      ctrlClear
);

   import rhRegPkg::*;
   import rhDmaPkg::*;

   logic    cs1LoWrite;
   logic    cs2LoWrite;
   // Function code as read back in CS1
   rhFunc_t funcReg;

   assign cs1LoWrite = regWrite.cs1 && regWrite.loByte;
   assign cs2LoWrite = regWrite.cs2 && regWrite.loByte;

   // GO only counts while idle
   assign goStart = cs1LoWrite && regWrite.data[cs1GoBit] && ready;

   always_ff @(posedge clk)
   begin
      if (!rstN)
      begin
         ready      <= 1'b1;
         incInhibit <= 1'b0;
         ctrlClear  <= 1'b0;
         funcReg    <= '0;
         func       <= '0;
      end
      else
      begin
         // One cycle pulse after the CS2 write
         ctrlClear <= cs2LoWrite && regWrite.data[cs2ClrBit];
         if (ctrlClear)
         begin
            ready      <= 1'b1;
            incInhibit <= 1'b0;
            funcReg    <= '0;
            func       <= '0;
         end
         else
         begin
            if (seqDone)
               ready <= 1'b1;
            else if (goStart)
               ready <= 1'b0;
            // Written even while busy
            if (cs1LoWrite)
               funcReg <= regWrite.data[cs1FuncMsb:cs1FuncLsb];
            // Command code frozen for the whole sequence
            if (goStart)
               func <= regWrite.data[cs1FuncMsb:cs1FuncLsb];
            if (cs2LoWrite)
               incInhibit <= regWrite.data[cs2BaiBit];
         end
      end
   end

   ///////////////////////////////////////////////////////////////////
   // Read-back images, GO and CLR read as zero
   always_comb
   begin
      cs1Value                        = '0;
      cs1Value[cs1FuncMsb:cs1FuncLsb] = funcReg;
      cs1Value[cs1RdyBit]             = ready;
      cs1Value[cs1BaeMsb:cs1BaeLsb]   = baExt;
   end

   always_comb
   begin
      cs2Value            = '0;
      cs2Value[cs2BaiBit] = incInhibit;
   end

   // GO drops ready on the next edge
   assert property (@(posedge clk) disable iff (!rstN)
      goStart |=> !ready);

endmodule

`default_nettype wire

// ==== design/rhBusAddress.sv ====
//////////////////////////////////////////////////////////////////////
// 18-bit bus address register
// Byte lane load, extension load from CS1, word increment
//////////////////////////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/100ps

module rhBusAddress (
   input  wire                       clk,
   input  wire                       rstN,
   input  wire rhRegPkg::rhRegWrite_t regWrite,
   input  wire                       ready,
   input  wire                       ctrlClear,
   input  wire                       incInhibit,
   input  wire                       wordDone,
   output logic [rhDmaPkg::rhAddrWidth-1:0] busAddr,
   output logic [15:0]               baValue,
   output logic [1:0]                baExt
);

   import rhRegPkg::*;

   // Word address, bit 0 is implied zero
   logic [17:1] addr;
   logic        extLoad;
   logic        incStep;

   // BAE only writable while idle
   assign extLoad = regWrite.cs1 && regWrite.hiByte && ready;
   assign incStep = wordDone && !incInhibit;

   always_ff @(posedge clk)
   begin
      if (!rstN || ctrlClear)
         addr <= '0;
      else if (extLoad)
         addr[17:16] <= regWrite.data[cs1BaeMsb:cs1BaeLsb];
      else if (regWrite.ba)
      begin
         if (regWrite.hiByte)
            addr[15:8] <= regWrite.data[15:8];
         if (regWrite.loByte)
            addr[7:1] <= regWrite.data[7:1];
      end
      else if (incStep)
         // Plus one word is plus two bytes
         addr <= addr + 1'b1;
   end

   assign busAddr = {addr, 1'b0};
   assign baValue = busAddr[15:0];
   assign baExt   = busAddr[17:16];

   // Words only move while busy, so a BAE load never meets a step
   assert property (@(posedge clk) disable iff (!rstN)
      wordDone |-> !ready);

endmodule

`default_nettype wire

// ==== design/rhWordCount.sv ====
//////////////////////////////////////////////////////////////////////
// Word count register
// Counts up towards zero, flags the final word
//////////////////////////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/100ps

module rhWordCount #(
   parameter int countWidth = 16
) (
   input  wire                       clk,
   input  wire                       rstN,
   input  wire rhRegPkg::rhRegWrite_t regWrite,
   input  wire                       ctrlClear,
   input  wire                       wordDone,
   output logic [15:0]               wcValue,
   output logic                      lastWord
);

   logic [countWidth-1:0] count;
   // Lane merge at full register width
   logic [15:0]           loadValue;

   assign wcValue = 16'(count);

   always_comb
   begin
      loadValue = wcValue;
      if (regWrite.hiByte)
         loadValue[15:8] = regWrite.data[15:8];
      if (regWrite.loByte)
         loadValue[7:0] = regWrite.data[7:0];
   end

   always_ff @(posedge clk)
   begin
      if (!rstN || ctrlClear)
         count <= '0;
      // Host write beats the increment
      else if (regWrite.wc)
         count <= loadValue[countWidth-1:0];
      else if (wordDone)
         count <= count + 1'b1;
   end

   // All ones, next word wraps to zero
   assign lastWord = &count;

endmodule

`default_nettype wire

// ==== design/rhDmaSequencer.sv ====
//////////////////////////////////////////////////////////////////////
// DMA sequencer
// Idle/active FSM issuing one request per word
//////////////////////////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/100ps

module rhDmaSequencer (
   input  wire                              clk,
   input  wire                              rstN,
   input  wire                              goStart,
   input  wire                              ctrlClear,
   input  wire  [rhDmaPkg::rhAddrWidth-1:0] busAddr,
   input  wire rhDmaPkg::rhFunc_t           func,
   input  wire                              lastWord,
   output rhDmaPkg::rhDmaReq_t              dmaReq,
   output logic                             dmaValid,
   input  wire                              dmaReady,
   output logic                             wordDone,
   output logic                             seqDone
);

   typedef enum logic {
      seqIdle,
      seqActive
   } seqState_t;

   seqState_t state;

   ///////////////////////////////////////////////////////////////////
   // FSM
   always_ff @(posedge clk)
   begin
      if (!rstN)
         state <= seqIdle;
      else
      begin
         case (state)
            seqIdle:
               if (goStart)
                  state <= seqActive;
            default:
               // Clear aborts mid-sequence
               if (ctrlClear || seqDone)
                  state <= seqIdle;
         endcase
      end
   end

   assign dmaValid = (state == seqActive);

   // Address and function come straight from the registers
   assign dmaReq.addr = busAddr;
   assign dmaReq.func = func;

   // One accepted word
   assign wordDone = dmaValid && dmaReady;
   // Final word taken, back to ready
   assign seqDone  = wordDone && lastWord;

   // Request holds until accepted, unless aborted
   assert property (@(posedge clk) disable iff (!rstN)
      dmaValid && !dmaReady && !ctrlClear |=> dmaValid && $stable(dmaReq));

endmodule

`default_nettype wire

// ==== design/rhController.sv ====
//////////////////////////////////////////////////////////////////////
// RH11-style controller top level
// Host register access and DMA word requests
//////////////////////////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/100ps

module rhController #(
   parameter int countWidth = 16
) (
   input  wire                       clk,
   input  wire                       rstN,
   input  wire rhRegPkg::rhHostReq_t  hostReq,
   input  wire                       hostReqValid,
   output logic                      hostReqReady,
   output rhRegPkg::rhHostRsp_t      hostRsp,
   output logic                      hostRspValid,
   input  wire                       hostRspReady,
   output rhDmaPkg::rhDmaReq_t       dmaReq,
   output logic                      dmaValid,
   input  wire                       dmaReady
);

   import rhRegPkg::*;
   import rhDmaPkg::*;

   rhRegWrite_t            regWrite;
   logic [15:0]            cs1Value;
   logic [15:0]            wcValue;
   logic [15:0]            baValue;
   logic [15:0]            cs2Value;
   rhFunc_t                func;
   logic                   goStart;
   logic                   ready;
   logic                   incInhibit;
   logic                   ctrlClear;
   logic [rhAddrWidth-1:0] busAddr;
   logic [1:0]             baExt;
   logic                   lastWord;
   logic                   wordDone;
   logic                   seqDone;

   ///////////////////////////////////////////////////////////////////
   // Host side
   rhRegDecode i_regDecode (
      .clk(clk), .rstN(rstN),
      .hostReq(hostReq), .hostReqValid(hostReqValid), .hostReqReady(hostReqReady),
      .hostRsp(hostRsp), .hostRspValid(hostRspValid), .hostRspReady(hostRspReady),
      .regWrite(regWrite),
      .cs1Value(cs1Value), .wcValue(wcValue), .baValue(baValue), .cs2Value(cs2Value)
   );

   rhControlStatus i_controlStatus (
      .clk(clk), .rstN(rstN), .regWrite(regWrite), .seqDone(seqDone), .baExt(baExt),
      .cs1Value(cs1Value), .cs2Value(cs2Value), .func(func), .goStart(goStart),
      .ready(ready), .incInhibit(incInhibit), .ctrlClear(ctrlClear)
   );

   // Address and count registers
   rhBusAddress i_busAddress (
      .clk(clk), .rstN(rstN), .regWrite(regWrite), .ready(ready),
      .ctrlClear(ctrlClear), .incInhibit(incInhibit), .wordDone(wordDone),
      .busAddr(busAddr), .baValue(baValue), .baExt(baExt)
   );

   rhWordCount #(.countWidth(countWidth)) i_wordCount (
      .clk(clk), .rstN(rstN), .regWrite(regWrite), .ctrlClear(ctrlClear),
      .wordDone(wordDone), .wcValue(wcValue), .lastWord(lastWord)
   );

   // DMA side
   rhDmaSequencer i_dmaSequencer (
      .clk(clk), .rstN(rstN), .goStart(goStart), .ctrlClear(ctrlClear),
      .busAddr(busAddr), .func(func), .lastWord(lastWord),
      .dmaReq(dmaReq), .dmaValid(dmaValid), .dmaReady(dmaReady),
      .wordDone(wordDone), .seqDone(seqDone)
   );

endmodule

`default_nettype wire

// ==== sim/rhControllerTb.sv ====
//////////////////////////////////////////////////////////////////////
// Testbench for the RH11-style controller
// Host bus driver, DMA consumer with random ready, data file replay
//////////////////////////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/100ps

module rhControllerTb;

   import rhRegPkg::*;
   import rhDmaPkg::*;

   // Operation codes in the data file
   localparam logic [15:0] opWrite = 16'h0001;
   localparam logic [15:0] opRead  = 16'h0002;
   localparam logic [15:0] opRun   = 16'h0003;
   localparam logic [15:0] opEnd   = 16'h000F;
   localparam int maxOps    = 64;
   localparam int waitLimit = 1000;

   logic        clk = 1'b0;
   logic        rstN;
   rhHostReq_t  hostReq;
   logic        hostReqValid;
   logic        hostReqReady;
   rhHostRsp_t  hostRsp;
   logic        hostRspValid;
   logic        hostRspReady;
   rhDmaReq_t   dmaReq;
   logic        dmaValid;
   logic        dmaReady = 1'b0;

   // Five columns per operation
   logic [15:0] vecMem [0:5*maxOps-1];

   // DMA consumer state, counted from the start of the run
   rhDmaReq_t   dmaQueue [$];
   int          dmaCount = 0;
   int          dmaLimit = 0;
   logic [15:0] lfsrState = 16'd34;

   // Expected 18-bit address and inhibit, tracked from the data file
   logic [17:0] expBa;
   logic        expInhibit;
   int          errorCount;
   int          checkCount;
   int          timeoutCount;

   rhController #(.countWidth(8)) i_dut (
      .clk(clk), .rstN(rstN),
      .hostReq(hostReq), .hostReqValid(hostReqValid), .hostReqReady(hostReqReady),
      .hostRsp(hostRsp), .hostRspValid(hostRspValid), .hostRspReady(hostRspReady),
      .dmaReq(dmaReq), .dmaValid(dmaValid), .dmaReady(dmaReady)
   );

   always #50 clk = !clk;

   // Galois form, taps 16,14,13,11
   function automatic logic [15:0] lfsrNext(input logic [15:0] state);
      if (state[0])
         return (state >> 1) ^ 16'hB400;
      else
         return state >> 1;
   endfunction

   ///////////////////////////////////////////////////////////////////
   // DMA consumer
   // Ready is set first, then a word seen with ready is taken on the next rise
   always @(negedge clk)
   begin
      if (rstN && dmaCount < dmaLimit)
      begin
         lfsrState = lfsrNext(lfsrState);
         dmaReady  = lfsrState[0];
      end
      else
         dmaReady = 1'b0;
      if (dmaValid && dmaReady)
      begin
         dmaQueue.push_back(dmaReq);
         dmaCount++;
      end
   end

   task automatic checkValue(input string what, input logic [31:0] got,
                             input logic [31:0] want);
      checkCount++;
      assert (got === want) else
      begin
         errorCount++;
         $display("error at %0d ns: %s is 0x%0h, expected 0x%0h", $time, what, got, want);
      end
   endtask

   ///////////////////////////////////////////////////////////////////
   // One host access, optionally holding the response back
   task automatic hostAccess(input logic wr, input rhRegOffset_t off, input logic [1:0] lanes,
                             input logic [15:0] data, input int holdCycles,
                             output logic [15:0] rspData);
      int waitCount;
      rspData = 16'h0000;
      if (timeoutCount != 0)
         return;
      @(negedge clk);
      hostReq.write  = wr;
      hostReq.offset = off;
      hostReq.loByte = lanes[0];
      hostReq.hiByte = lanes[1];
      hostReq.data   = data;
      hostReqValid   = 1'b1;
      hostRspReady   = (holdCycles == 0);
      waitCount      = 0;
      while (!hostReqReady && waitCount < waitLimit)
      begin
         @(negedge clk);
         waitCount++;
      end
      if (!hostReqReady)
      begin
         timeoutCount++;
         hostReqValid = 1'b0;
         $display("timeout: the host request was never accepted");
         return;
      end
      @(negedge clk);
      // Under back-pressure a second request stays offered
      hostReqValid = (holdCycles != 0);
      waitCount    = 0;
      while (!hostRspValid && waitCount < waitLimit)
      begin
         @(negedge clk);
         waitCount++;
      end
      if (!hostRspValid)
      begin
         timeoutCount++;
         hostReqValid = 1'b0;
         $display("timeout: no host response arrived");
         return;
      end
      rspData = hostRsp.data;
      for (int i = 0; i < holdCycles; i++)
      begin
         @(negedge clk);
         checkValue("hostReqReady under back-pressure", 32'(hostReqReady), 32'd0);
         checkValue("hostRspValid under back-pressure", 32'(hostRspValid), 32'd1);
         checkValue("pending response data", 32'(hostRsp.data), 32'(rspData));
      end
      hostReqValid = 1'b0;
      hostRspReady = 1'b1;
      @(negedge clk);
   endtask

   // Compare read-back and follow the address and inhibit state
   task automatic checkRegister(input rhRegOffset_t off, input logic [15:0] got,
                                input logic [15:0] want);
      if (timeoutCount != 0)
         return;
      checkValue($sformatf("register %0d read-back", off), 32'(got), 32'(want));
      case (off)
         cs1Offset: expBa[17:16] = want[cs1BaeMsb:cs1BaeLsb];
         baOffset:  expBa[15:0]  = want;
         cs2Offset: expInhibit   = want[cs2BaiBit];
         default:   expInhibit   = expInhibit;
      endcase
   endtask

   ///////////////////////////////////////////////////////////////////
   // GO, then collect the expected number of words
   task automatic runTransfer(input logic stopEarly, input logic [15:0] goData,
                              input int words);
      logic [15:0] rspData;
      logic [17:0] expAddr;
      int          firstWord;
      int          waitCount;
      if (timeoutCount != 0)
         return;
      @(negedge clk);
      checkValue("dmaValid before GO", 32'(dmaValid), 32'd0);
      @(posedge clk);
      firstWord = dmaCount;
      dmaLimit  = dmaCount + words;
      hostAccess(1'b1, cs1Offset, 2'b01, goData, 0, rspData);
      if (timeoutCount != 0)
         return;
      checkValue("RDY in the GO response", 32'(rspData[cs1RdyBit]), 32'd0);
      waitCount = 0;
      do
      begin
         @(posedge clk);
         waitCount++;
      end
      while (dmaCount < dmaLimit && waitCount < waitLimit);
      if (dmaCount < dmaLimit)
      begin
         timeoutCount++;
         $display("timeout: only %0d of %0d DMA requests arrived", dmaCount - firstWord, words);
         return;
      end
      // Sequence must end right after the final word
      if (!stopEarly)
      begin
         @(negedge clk);
         checkValue("dmaValid after the final word", 32'(dmaValid), 32'd0);
      end
      expAddr = expBa;
      for (int k = 0; k < words; k++)
      begin
         checkValue($sformatf("DMA address of word %0d", k),
                    32'(dmaQueue[firstWord + k].addr), 32'(expAddr));
         checkValue($sformatf("DMA function of word %0d", k),
                    32'(dmaQueue[firstWord + k].func), 32'(goData[cs1FuncMsb:cs1FuncLsb]));
         if (!expInhibit)
            expAddr = expAddr + 18'd2;
      end
   endtask

   ///////////////////////////////////////////////////////////////////
   // Main sequence
   initial
   begin
      logic [15:0] opCode;
      logic [15:0] opOffset;
      logic [15:0] opMask;
      logic [15:0] opData;
      logic [15:0] opExpected;
      logic [15:0] rspData;
      rstN         = 1'b0;
      hostReq      = '0;
      hostReqValid = 1'b0;
      hostRspReady = 1'b1;
      expBa        = '0;
      expInhibit   = 1'b0;
      errorCount   = 0;
      checkCount   = 0;
      timeoutCount = 0;
      $readmemh("sim/rhInput.txt", vecMem);
      repeat (10) @(negedge clk);
      rstN = 1'b1;
      checkValue("hostReqReady after reset", 32'(hostReqReady), 32'd1);
      checkValue("hostRspValid after reset", 32'(hostRspValid), 32'd0);
      checkValue("dmaValid after reset", 32'(dmaValid), 32'd0);
      for (int opIndex = 0; opIndex < maxOps; opIndex++)
      begin
         opCode     = vecMem[opIndex*5];
         opOffset   = vecMem[opIndex*5 + 1];
         opMask     = vecMem[opIndex*5 + 2];
         opData     = vecMem[opIndex*5 + 3];
         opExpected = vecMem[opIndex*5 + 4];
         if (timeoutCount != 0 || opCode == opEnd)
            break;
         case (opCode)
            opWrite:
            begin
               hostAccess(1'b1, opOffset[1:0], opMask[1:0], opData, 0, rspData);
               checkRegister(opOffset[1:0], rspData, opExpected);
            end
            opRead:
            begin
               // Mask column is the back-pressure hold for a read
               hostAccess(1'b0, opOffset[1:0], 2'b00, 16'h0000, int'(opMask), rspData);
               checkRegister(opOffset[1:0], rspData, opExpected);
            end
            opRun:
               runTransfer(opOffset != 16'h0000, opData, int'(opExpected));
            default:
            begin
               errorCount++;
               $display("unknown operation %0h on line %0d of the data file", opCode, opIndex);
            end
         endcase
      end
      $display("checks: %0d, errors: %0d, timeouts: %0d", checkCount, errorCount, timeoutCount);
      if (errorCount == 0 && timeoutCount == 0)
         $display("test passed");
      else
         $display("test failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== sim/rhInput.txt ====
// op offset mask data expected, op 1 write, 2 read, 3 run, f end
// mask bit 0 low lane, bit 1 high lane; read: hold cycles; run: offset 1 stops early
2 0 0 0000 0080
1 2 3 1234 1234
1 2 1 00ff 12fe
1 2 2 ab00 abfe
1 2 0 5555 abfe
1 2 3 0101 0100
1 0 2 0300 0380
2 2 0 0000 0100
1 1 3 fffa 00fa
3 0 0 0009 0006
2 0 0 0000 0388
2 1 0 0000 0000
2 2 0 0000 010c
1 3 1 0008 0008
1 1 1 00fc 00fc
3 0 0 0013 0004
2 2 0 0000 010c
2 1 0 0000 0000
1 3 1 0000 0000
1 1 3 00f0 00f0
3 1 0 0005 0003
1 0 2 0100 0304
2 1 0 0000 00f3
2 2 0 0000 0112
1 3 1 0020 0000
2 0 0 0000 0080
2 1 0 0000 0000
2 2 0 0000 0000
1 2 3 0246 0246
2 2 4 0000 0246
1 1 3 00fd 00fd
3 0 0 0003 0003
2 2 0 0000 024c
2 0 0 0000 0082
f 0 0 0000 0000

// ==== verilog.f ====
design/rhRegPkg.sv
design/rhDmaPkg.sv
design/rhRegDecode.sv
design/rhControlStatus.sv
design/rhBusAddress.sv
design/rhWordCount.sv
design/rhDmaSequencer.sv
design/rhController.sv
sim/rhControllerTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := rhControllerTb
FILELIST  := verilog.f
OBJDIR    := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -qx "test passed" $(LOG) || (echo "simulation reported failure"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)
